//--- design/opl3_out_pkg.sv
package opl3_out_pkg;

	// log-sine attenuation from the sine table
	localparam int LOGSIN_W = 12;

	// envelope level, weighted by 8 before the add
	localparam int ENV_W = 9;

	// summed attenuation: [12:8] shift count, [7:0] fraction
	localparam int ATT_W = 13;

	// exponent table mantissa
	localparam int EXP_W = 10;

	// signed linear sample
	localparam int OUT_W = 14;

endpackage

//--- design/opl3_exp_lut.sv
`timescale 1ns/1ps

module opl3_exp_lut (
	input logic clk,
	input logic [7:0] in,
	output logic [opl3_out_pkg::EXP_W-1:0] out
);
	// 1024 * (2^(in/256) - 1), one cycle latency
	always_ff @(posedge clk) begin
		case (in)
			8'h00: out <= 10'd0;
			8'h01: out <= 10'd3;
			8'h02: out <= 10'd6;
			8'h03: out <= 10'd8;
			8'h04: out <= 10'd11;
			8'h05: out <= 10'd14;
			8'h06: out <= 10'd17;
			8'h07: out <= 10'd20;
			8'h08: out <= 10'd22;
			8'h09: out <= 10'd25;
			8'h0a: out <= 10'd28;
			8'h0b: out <= 10'd31;
			8'h0c: out <= 10'd34;
			8'h0d: out <= 10'd37;
			8'h0e: out <= 10'd40;
			8'h0f: out <= 10'd42;
			8'h10: out <= 10'd45;
			8'h11: out <= 10'd48;
			8'h12: out <= 10'd51;
			8'h13: out <= 10'd54;
			8'h14: out <= 10'd57;
			8'h15: out <= 10'd60;
			8'h16: out <= 10'd63;
			8'h17: out <= 10'd66;
			8'h18: out <= 10'd69;
			8'h19: out <= 10'd72;
			8'h1a: out <= 10'd75;
			8'h1b: out <= 10'd78;
			8'h1c: out <= 10'd81;
			8'h1d: out <= 10'd84;
			8'h1e: out <= 10'd87;
			8'h1f: out <= 10'd90;
			8'h20: out <= 10'd93;
			8'h21: out <= 10'd96;
			8'h22: out <= 10'd99;
			8'h23: out <= 10'd102;
			8'h24: out <= 10'd105;
			8'h25: out <= 10'd108;
			8'h26: out <= 10'd111;
			8'h27: out <= 10'd114;
			8'h28: out <= 10'd117;
			8'h29: out <= 10'd120;
			8'h2a: out <= 10'd123;
			8'h2b: out <= 10'd126;
			8'h2c: out <= 10'd130;
			8'h2d: out <= 10'd133;
			8'h2e: out <= 10'd136;
			8'h2f: out <= 10'd139;
			8'h30: out <= 10'd142;
			8'h31: out <= 10'd145;
			8'h32: out <= 10'd148;
			8'h33: out <= 10'd152;
			8'h34: out <= 10'd155;
			8'h35: out <= 10'd158;
			8'h36: out <= 10'd161;
			8'h37: out <= 10'd164;
			8'h38: out <= 10'd168;
			8'h39: out <= 10'd171;
			8'h3a: out <= 10'd174;
			8'h3b: out <= 10'd177;
			8'h3c: out <= 10'd181;
			8'h3d: out <= 10'd184;
			8'h3e: out <= 10'd187;
			8'h3f: out <= 10'd190;
			8'h40: out <= 10'd194;
			8'h41: out <= 10'd197;
			8'h42: out <= 10'd200;
			8'h43: out <= 10'd204;
			8'h44: out <= 10'd207;
			8'h45: out <= 10'd210;
			8'h46: out <= 10'd214;
			8'h47: out <= 10'd217;
			8'h48: out <= 10'd220;
			8'h49: out <= 10'd224;
			8'h4a: out <= 10'd227;
			8'h4b: out <= 10'd231;
			8'h4c: out <= 10'd234;
			8'h4d: out <= 10'd237;
			8'h4e: out <= 10'd241;
			8'h4f: out <= 10'd244;
			8'h50: out <= 10'd248;
			8'h51: out <= 10'd251;
			8'h52: out <= 10'd255;
			8'h53: out <= 10'd258;
			8'h54: out <= 10'd262;
			8'h55: out <= 10'd265;
			8'h56: out <= 10'd268;
			8'h57: out <= 10'd272;
			8'h58: out <= 10'd276;
			8'h59: out <= 10'd279;
			8'h5a: out <= 10'd283;
			8'h5b: out <= 10'd286;
			8'h5c: out <= 10'd290;
			8'h5d: out <= 10'd293;
			8'h5e: out <= 10'd297;
			8'h5f: out <= 10'd300;
			8'h60: out <= 10'd304;
			8'h61: out <= 10'd308;
			8'h62: out <= 10'd311;
			8'h63: out <= 10'd315;
			8'h64: out <= 10'd318;
			8'h65: out <= 10'd322;
			8'h66: out <= 10'd326;
			8'h67: out <= 10'd329;
			8'h68: out <= 10'd333;
			8'h69: out <= 10'd337;
			8'h6a: out <= 10'd340;
			8'h6b: out <= 10'd344;
			8'h6c: out <= 10'd348;
			8'h6d: out <= 10'd352;
			8'h6e: out <= 10'd355;
			8'h6f: out <= 10'd359;
			8'h70: out <= 10'd363;
			8'h71: out <= 10'd367;
			8'h72: out <= 10'd370;
			8'h73: out <= 10'd374;
			8'h74: out <= 10'd378;
			8'h75: out <= 10'd382;
			8'h76: out <= 10'd385;
			8'h77: out <= 10'd389;
			8'h78: out <= 10'd393;
			8'h79: out <= 10'd397;
			8'h7a: out <= 10'd401;
			8'h7b: out <= 10'd405;
			8'h7c: out <= 10'd409;
			8'h7d: out <= 10'd412;
			8'h7e: out <= 10'd416;
			8'h7f: out <= 10'd420;
			8'h80: out <= 10'd424;
			8'h81: out <= 10'd428;
			8'h82: out <= 10'd432;
			8'h83: out <= 10'd436;
			8'h84: out <= 10'd440;
			8'h85: out <= 10'd444;
			8'h86: out <= 10'd448;
			8'h87: out <= 10'd452;
			8'h88: out <= 10'd456;
			8'h89: out <= 10'd460;
			8'h8a: out <= 10'd464;
			8'h8b: out <= 10'd468;
			8'h8c: out <= 10'd472;
			8'h8d: out <= 10'd476;
			8'h8e: out <= 10'd480;
			8'h8f: out <= 10'd484;
			8'h90: out <= 10'd488;
			8'h91: out <= 10'd492;
			8'h92: out <= 10'd496;
			8'h93: out <= 10'd501;
			8'h94: out <= 10'd505;
			8'h95: out <= 10'd509;
			8'h96: out <= 10'd513;
			8'h97: out <= 10'd517;
			8'h98: out <= 10'd521;
			8'h99: out <= 10'd526;
			8'h9a: out <= 10'd530;
			8'h9b: out <= 10'd534;
			8'h9c: out <= 10'd538;
			8'h9d: out <= 10'd542;
			8'h9e: out <= 10'd547;
			8'h9f: out <= 10'd551;
			8'ha0: out <= 10'd555;
			8'ha1: out <= 10'd560;
			8'ha2: out <= 10'd564;
			8'ha3: out <= 10'd568;
			8'ha4: out <= 10'd572;
			8'ha5: out <= 10'd577;
			8'ha6: out <= 10'd581;
			8'ha7: out <= 10'd585;
			8'ha8: out <= 10'd590;
			8'ha9: out <= 10'd594;
			8'haa: out <= 10'd599;
			8'hab: out <= 10'd603;
			8'hac: out <= 10'd607;
			8'had: out <= 10'd612;
			8'hae: out <= 10'd616;
			8'haf: out <= 10'd621;
			8'hb0: out <= 10'd625;
			8'hb1: out <= 10'd630;
			8'hb2: out <= 10'd634;
			8'hb3: out <= 10'd639;
			8'hb4: out <= 10'd643;
			8'hb5: out <= 10'd648;
			8'hb6: out <= 10'd652;
			8'hb7: out <= 10'd657;
			8'hb8: out <= 10'd661;
			8'hb9: out <= 10'd666;
			8'hba: out <= 10'd670;
			8'hbb: out <= 10'd675;
			8'hbc: out <= 10'd680;
			8'hbd: out <= 10'd684;
			8'hbe: out <= 10'd689;
			8'hbf: out <= 10'd693;
			8'hc0: out <= 10'd698;
			8'hc1: out <= 10'd703;
			8'hc2: out <= 10'd708;
			8'hc3: out <= 10'd712;
			8'hc4: out <= 10'd717;
			8'hc5: out <= 10'd722;
			8'hc6: out <= 10'd726;
			8'hc7: out <= 10'd731;
			8'hc8: out <= 10'd736;
			8'hc9: out <= 10'd741;
			8'hca: out <= 10'd745;
			8'hcb: out <= 10'd750;
			8'hcc: out <= 10'd755;
			8'hcd: out <= 10'd760;
			8'hce: out <= 10'd765;
			8'hcf: out <= 10'd770;
			8'hd0: out <= 10'd774;
			8'hd1: out <= 10'd779;
			8'hd2: out <= 10'd784;
			8'hd3: out <= 10'd789;
			8'hd4: out <= 10'd794;
			8'hd5: out <= 10'd799;
			8'hd6: out <= 10'd804;
			8'hd7: out <= 10'd809;
			8'hd8: out <= 10'd814;
			8'hd9: out <= 10'd819;
			8'hda: out <= 10'd824;
			8'hdb: out <= 10'd829;
			8'hdc: out <= 10'd834;
			8'hdd: out <= 10'd839;
			8'hde: out <= 10'd844;
			8'hdf: out <= 10'd849;
			8'he0: out <= 10'd854;
			8'he1: out <= 10'd859;
			8'he2: out <= 10'd864;
			8'he3: out <= 10'd869;
			8'he4: out <= 10'd874;
			8'he5: out <= 10'd880;
			8'he6: out <= 10'd885;
			8'he7: out <= 10'd890;
			8'he8: out <= 10'd895;
			8'he9: out <= 10'd900;
			8'hea: out <= 10'd906;
			8'heb: out <= 10'd911;
			8'hec: out <= 10'd916;
			8'hed: out <= 10'd921;
			8'hee: out <= 10'd927;
			8'hef: out <= 10'd932;
			8'hf0: out <= 10'd937;
			8'hf1: out <= 10'd942;
			8'hf2: out <= 10'd948;
			8'hf3: out <= 10'd953;
			8'hf4: out <= 10'd959;
			8'hf5: out <= 10'd964;
			8'hf6: out <= 10'd969;
			8'hf7: out <= 10'd975;
			8'hf8: out <= 10'd980;
			8'hf9: out <= 10'd986;
			8'hfa: out <= 10'd991;
			8'hfb: out <= 10'd996;
			8'hfc: out <= 10'd1002;
			8'hfd: out <= 10'd1007;
			8'hfe: out <= 10'd1013;
			8'hff: out <= 10'd1018;
		endcase
	end

endmodule

//--- design/att_mixer.sv
`timescale 1ns/1ps

module att_mixer #(
	parameter int FIFO_DEPTH = 4
) (
	input logic clk,
	input logic reset,
	input logic in_valid,
	input logic in_sign,
	input logic [opl3_out_pkg::LOGSIN_W-1:0] in_logsin,
	input logic [opl3_out_pkg::ENV_W-1:0] in_env,
	input logic credit_return,
	output logic in_ready,
	output logic push,
	output logic push_sign,
	output logic [opl3_out_pkg::ATT_W-1:0] push_att
);
	import opl3_out_pkg::*;

	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	logic [CNT_W-1:0] credits;
	logic accept;
	logic [ATT_W:0] sum_wide;
	logic [ATT_W-1:0] sum_sat;

	assign in_ready = (credits != '0);
	assign accept = in_valid & in_ready;

	// envelope counts in steps of 8 log units
	assign sum_wide = (ATT_W + 1)'(in_logsin) + (ATT_W + 1)'({in_env, 3'b000});
	assign sum_sat = sum_wide[ATT_W] ? '1 : sum_wide[ATT_W-1:0];

	always_ff @(posedge clk) begin
		if (reset) begin
			credits <= CNT_W'(FIFO_DEPTH);
			push <= 1'b0;
		end else begin
			push <= accept;
			if (accept && !credit_return)
				credits <= credits - 1'b1;
			else if (!accept && credit_return)
				credits <= credits + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			push_sign <= in_sign;
			push_att <= sum_sat;
		end
	end

endmodule

//--- design/att_fifo.sv
`timescale 1ns/1ps

module att_fifo #(
	parameter int FIFO_DEPTH = 4
) (
	input logic clk,
	input logic reset,
	input logic push,
	input logic push_sign,
	input logic [opl3_out_pkg::ATT_W-1:0] push_att,
	input logic pop,
	output logic not_empty,
	output logic pop_sign,
	output logic [opl3_out_pkg::ATT_W-1:0] pop_att
);
	import opl3_out_pkg::*;

	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	logic mem_sign [FIFO_DEPTH];
	logic [ATT_W-1:0] mem_att [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic do_pop;

	assign not_empty = (count != '0);
	assign do_pop = pop & not_empty;
	assign pop_sign = mem_sign[rd_ptr];
	assign pop_att = mem_att[rd_ptr];

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			count <= count + CNT_W'(push) - CNT_W'(do_pop);
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			mem_sign[wr_ptr] <= push_sign;
			mem_att[wr_ptr] <= push_att;
		end
	end

endmodule

//--- design/log_to_linear.sv
`timescale 1ns/1ps

module log_to_linear (
	input logic clk,
	input logic reset,
	input logic not_empty,
	input logic pop_sign,
	input logic [opl3_out_pkg::ATT_W-1:0] pop_att,
	input logic out_ready,
	output logic pop,
	output logic credit_return,
	output logic out_valid,
	output logic signed [opl3_out_pkg::OUT_W-1:0] out_sample
);
	import opl3_out_pkg::*;

	logic idx_valid;
	logic idx_settled; // table output belongs to the word in idx_frac
	logic [7:0] idx_frac;
	logic [ATT_W-9:0] idx_shift;
	logic idx_sign;
	logic [EXP_W-1:0] exp_frac;
	logic [EXP_W+1:0] mant;
	logic [EXP_W+1:0] mag;
	logic out_load;

	opl3_exp_lut exp_lut0 (
		.clk(clk),
		.in(idx_frac),
		.out(exp_frac)
	);

	assign out_load = idx_valid & idx_settled & (~out_valid | out_ready);
	assign pop = not_empty & (~idx_valid | out_load);
	assign credit_return = pop; // one credit per popped word

	assign mant = {1'b1, exp_frac, 1'b0}; // (1024 + table) * 2
	assign mag = mant >> idx_shift;

	always_ff @(posedge clk) begin
		if (reset) begin
			idx_valid <= 1'b0;
			idx_settled <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			if (pop)
				idx_valid <= 1'b1;
			else if (out_load)
				idx_valid <= 1'b0;
			idx_settled <= idx_valid & ~pop;
			if (out_load)
				out_valid <= 1'b1;
			else if (out_ready)
				out_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (pop) begin
			idx_frac <= ~pop_att[7:0];
			idx_shift <= pop_att[ATT_W-1:8];
			idx_sign <= pop_sign;
		end
		// ones' complement for negative half
		if (out_load)
			out_sample <= idx_sign ? ~OUT_W'(mag) : OUT_W'(mag);
	end

endmodule

//--- design/opl3_out_path.sv
`timescale 1ns/1ps

module opl3_out_path #(
	parameter int FIFO_DEPTH = 4
) (
	input logic clk,
	input logic reset,
	input logic in_valid,
	input logic in_sign,
	input logic [opl3_out_pkg::LOGSIN_W-1:0] in_logsin,
	input logic [opl3_out_pkg::ENV_W-1:0] in_env,
	input logic out_ready,
	output logic in_ready,
	output logic out_valid,
	output logic signed [opl3_out_pkg::OUT_W-1:0] out_sample
);
	import opl3_out_pkg::*;

	logic push;
	logic push_sign;
	logic [ATT_W-1:0] push_att;
	logic not_empty;
	logic pop;
	logic pop_sign;
	logic [ATT_W-1:0] pop_att;
	logic credit_return;

	att_mixer #(.FIFO_DEPTH(FIFO_DEPTH)) mixer0 (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.in_sign(in_sign),
		.in_logsin(in_logsin),
		.in_env(in_env),
		.credit_return(credit_return),
		.in_ready(in_ready),
		.push(push),
		.push_sign(push_sign),
		.push_att(push_att)
	);

	att_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) fifo0 (
		.clk(clk),
		.reset(reset),
		.push(push),
		.push_sign(push_sign),
		.push_att(push_att),
		.pop(pop),
		.not_empty(not_empty),
		.pop_sign(pop_sign),
		.pop_att(pop_att)
	);

	log_to_linear conv0 (
		.clk(clk),
		.reset(reset),
		.not_empty(not_empty),
		.pop_sign(pop_sign),
		.pop_att(pop_att),
		.out_ready(out_ready),
		.pop(pop),
		.credit_return(credit_return),
		.out_valid(out_valid),
		.out_sample(out_sample)
	);

endmodule

//--- tb/tb_opl3_out_path.sv
`timescale 1ns/1ps

module tb_opl3_out_path;
	import opl3_out_pkg::*;

	localparam int FIFO_DEPTH = 4;
	localparam int N_TABLE = 256;
	localparam int N_RANDOM = 1500;
	localparam int N_SAT = 32;
	localparam int N_BP = 200;
	localparam int DRAIN_LIMIT = 200;
	localparam int MAX_CYCLES = 2000 * 20;
	localparam int SEED = 32'h04e2_ae87;

	logic clk = 1'b0;
	logic reset;
	logic in_valid;
	logic in_sign;
	logic [LOGSIN_W-1:0] in_logsin;
	logic [ENV_W-1:0] in_env;
	logic out_ready = 1'b1;
	logic in_ready;
	logic out_valid;
	logic signed [OUT_W-1:0] out_sample;

	int seed;
	int ready_seed;
	int ready_mode; // 0 always ready, 1 random, 2 stalled
	int exp_ref [256];
	logic [OUT_W-1:0] expected_q [$];
	int data_errors = 0;
	int protocol_errors = 0;
	int out_count = 0;
	int cycles = 0;
	logic held = 1'b0;
	logic [OUT_W-1:0] held_sample;

	opl3_out_path #(.FIFO_DEPTH(FIFO_DEPTH)) dut0 (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.in_sign(in_sign),
		.in_logsin(in_logsin),
		.in_env(in_env),
		.out_ready(out_ready),
		.in_ready(in_ready),
		.out_valid(out_valid),
		.out_sample(out_sample)
	);

	always #5 clk = ~clk;

	// 1024 * (2^(i/256) - 1), rounded to nearest
	function automatic void build_exp_table();
		real v;
		for (int i = 0; i < 256; i++) begin
			v = (2.0 ** (real'(i) / 256.0) - 1.0) * 1024.0;
			exp_ref[8'(i)] = $rtoi(v + 0.5);
		end
	endfunction

	function automatic logic [OUT_W-1:0] expected_sample(input logic sign,
			input logic [LOGSIN_W-1:0] logsin, input logic [ENV_W-1:0] env);
		int sum;
		int frac;
		int shift;
		int mag;
		sum = int'(logsin) + int'(env) * 8;
		if (sum > (1 << ATT_W) - 1)
			sum = (1 << ATT_W) - 1;
		frac = 255 - (sum % 256); // inverted fraction indexes the table
		shift = sum / 256;
		mag = ((1024 + exp_ref[8'(frac)]) * 2) >> shift;
		if (sign)
			return ~OUT_W'(mag);
		return OUT_W'(mag);
	endfunction

	task automatic send_word(input logic sign, input logic [LOGSIN_W-1:0] logsin,
			input logic [ENV_W-1:0] env);
		in_valid <= 1'b1;
		in_sign <= sign;
		in_logsin <= logsin;
		in_env <= env;
		@(posedge clk);
		while (!in_ready)
			@(posedge clk);
		in_valid <= 1'b0;
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		@(posedge clk);
		while (expected_q.size() != 0 && waited < DRAIN_LIMIT) begin
			@(posedge clk);
			waited++;
		end
		if (expected_q.size() != 0) begin
			$display("%0d expected samples never arrived", expected_q.size());
			protocol_errors++;
			expected_q.delete();
		end
		repeat (2) @(posedge clk);
	endtask

	task automatic print_counts();
		$display("errors: %0d data, %0d protocol, %0d samples checked",
			data_errors, protocol_errors, out_count);
	endtask

	always @(posedge clk) begin
		case (ready_mode)
			0: out_ready <= 1'b1;
			1: out_ready <= 1'($random(ready_seed));
			default: out_ready <= 1'b0;
		endcase
	end

	// scoreboard: outputs are compared before this edge's input is queued
	always @(posedge clk) begin
		logic [OUT_W-1:0] want;
		if (reset) begin
			held = 1'b0;
		end else begin
			if (held && (!out_valid || out_sample != held_sample)) begin
				$display("output sample dropped or changed while held at %0t", $time);
				protocol_errors++;
			end
			if (out_valid && out_ready) begin
				if (expected_q.size() == 0) begin
					$display("output sample %0d delivered with nothing outstanding", out_sample);
					protocol_errors++;
				end else begin
					want = expected_q.pop_front();
					if (out_sample != want) begin
						$display("** Error at %0t: sample %0d is %0d, expected %0d",
							$time, out_count, out_sample, $signed(want));
						data_errors++;
					end
					out_count++;
				end
			end
			if (in_valid && in_ready)
				expected_q.push_back(expected_sample(in_sign, in_logsin, in_env));
			if (expected_q.size() > FIFO_DEPTH + 2) begin
				$display("%0d words outstanding, more than the credit limit allows",
					expected_q.size());
				protocol_errors++;
			end
			held = out_valid && !out_ready;
			held_sample = out_sample;
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout after %0d cycles, the output stopped delivering samples", cycles);
			print_counts();
			$display("Checks failed");
			$finish;
		end
	end

	initial begin
		int accepted;
		seed = SEED;
		ready_seed = ~SEED;
		ready_mode = 0;
		build_exp_table();
		reset <= 1'b1;
		in_valid <= 1'b0;
		in_sign <= 1'b0;
		in_logsin <= '0;
		in_env <= '0;
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		@(posedge clk);
		if (out_valid || !in_ready) begin
			$display("after reset out_valid=%0b in_ready=%0b, expected 0 and 1",
				out_valid, in_ready);
			protocol_errors++;
		end

		// every table entry once, no shift
		for (int i = 0; i < N_TABLE; i++)
			send_word(1'b0, LOGSIN_W'(i), '0);
		wait_drain();

		for (int i = 0; i < N_RANDOM; i++) begin
			if (($random(seed) & 3) == 0)
				@(posedge clk);
			send_word(1'($random(seed)), LOGSIN_W'($random(seed)), ENV_W'($random(seed)));
		end
		wait_drain();

		// shift count of 15 and above leaves nothing of the mantissa
		for (int i = 0; i < N_SAT; i++) begin
			if (i < N_SAT / 2)
				send_word(1'($random(seed)), '1, '1);
			else
				send_word(1'($random(seed)), LOGSIN_W'($random(seed)),
					9'h1e0 | ENV_W'($random(seed)));
		end
		wait_drain();

		ready_mode <= 1;
		for (int i = 0; i < N_BP; i++)
			send_word(1'($random(seed)), LOGSIN_W'($random(seed)), ENV_W'($random(seed) & 31));
		wait_drain();

		// output stalled, so only the credits bound the accepted words
		ready_mode <= 2;
		repeat (3) @(posedge clk);
		accepted = 0;
		in_valid <= 1'b1;
		in_sign <= 1'($random(seed));
		in_logsin <= LOGSIN_W'($random(seed));
		in_env <= ENV_W'($random(seed) & 15);
		repeat (20) begin
			@(posedge clk);
			if (in_ready) begin
				accepted++;
				in_sign <= 1'($random(seed));
				in_logsin <= LOGSIN_W'($random(seed));
				in_env <= ENV_W'($random(seed) & 15);
			end
		end
		in_valid <= 1'b0;
		@(posedge clk);
		if (accepted > FIFO_DEPTH + 2) begin
			$display("%0d words accepted with the output stalled, limit is %0d",
				accepted, FIFO_DEPTH + 2);
			protocol_errors++;
		end
		if (in_ready) begin
			$display("in_ready still high with the output stalled and credits spent");
			protocol_errors++;
		end
		ready_mode <= 0;
		wait_drain();

		print_counts();
		if (data_errors + protocol_errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

//--- sim.f
design/opl3_out_pkg.sv
design/opl3_exp_lut.sv
design/att_mixer.sv
design/att_fifo.sv
design/log_to_linear.sv
design/opl3_out_path.sv
tb/tb_opl3_out_path.sv

//--- Makefile
VERILATOR ?= verilator
FILELIST ?= sim.f
TB_TOP ?= tb_opl3_out_path
RTL_TOP ?= opl3_out_path
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall
RTL_FILES ?= design/opl3_out_pkg.sv design/opl3_exp_lut.sv design/att_mixer.sv \
	design/att_fifo.sv design/log_to_linear.sv design/opl3_out_path.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR) -o V$(TB_TOP)

run: build
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	grep -q "All checks passed" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) $(RTL_FILES) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
